// ==== lcd_defines.svh ====
//******************************
// Bus timing and wait lengths
// All values in clock cycles
//******************************
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// RS and data valid before enable rises
`define LCD_SETUP_CYCLES 2

// Enable high time
`define LCD_PULSE_CYCLES 4

// Enable low before next write may start
// Must be at least 2, one of these cycles carries done
`define LCD_HOLD_CYCLES 4

// Wait after reset before first command
// Short value for simulation, board builds use about 15 ms worth
`define LCD_POWERUP_CYCLES 20

// Extra wait after clear display command
// Clear needs about 1.6 ms on a real panel
`define LCD_CLEAR_CYCLES 20

`endif

// ==== lcd_pkg.sv ====
//******************************
// Shared types for the 1602 driver
// Byte, row, counter, FSM states
// Fixed row texts
//******************************
package lcd_pkg;

	typedef logic [7:0] lcdByte_t;      // Command or character code
	typedef logic [127:0] lcdRow_t;     // 16 chars, leftmost in top byte
	typedef logic [4:0] lcdCount_t;     // Page pair count, 0..16

	// Sequencer states
	typedef enum logic [2:0]
	{
		powerUp,
		initCmd,
		clearWait,
		rowAddr,
		rowChars,
		pageDone,
		idle
	} funcState_t;

	// Bus writer phases
	typedef enum logic [1:0]
	{
		busIdle,
		busSetup,
		busPulse,
		busHold
	} busState_t;

	localparam lcdRow_t ROW_TITLE = " Subscriptions: ";
	localparam lcdRow_t ROW_GREET1 = " I am OpenFPGA!!";
	localparam lcdRow_t ROW_GREET2 = "!!!!Welcome!!!! ";   // Padded to 16
	localparam logic [103:0] ROW_NUMBER_PREFIX = " My  Number: ";   // 13 chars

endpackage

// ==== lcd_textgen.sv ====
//******************************
// Row text source
// Page pair counter and the
// ASCII counter row
//******************************
`timescale 1ns/10ps

module lcd_textgen
(
	input  logic             CLOCK,
	input  logic             RST_n,
	input  logic             pageDone,    // End of page pulse
	input  logic             pageB,       // Ending page was B
	output lcd_pkg::lcdRow_t rowTitle,
	output lcd_pkg::lcdRow_t rowNumber,
	output lcd_pkg::lcdRow_t rowGreet1,
	output lcd_pkg::lcdRow_t rowGreet2
);
	import lcd_pkg::*;

	localparam lcdCount_t COUNT_MAX = 5'd16;
	localparam lcdByte_t ASCII_ZERO = 8'h30;
	localparam lcdByte_t ASCII_SPACE = 8'h20;

	lcdCount_t pageCount;
	logic [3:0] tensVal;
	logic [3:0] onesVal;
	lcdByte_t tensChar;
	lcdByte_t onesChar;

	// Advances once per A/B pair between pages
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			pageCount <= '0;
		else if (pageDone && pageB)
			pageCount <= (pageCount == COUNT_MAX) ? '0 : pageCount + 5'd1;
	end

	// Binary to two decimal digits for counts below 20
	always_comb
	begin
		if (pageCount >= 5'd10)
		begin
			tensVal = 4'd1;
			onesVal = 4'(pageCount - 5'd10);
		end
		else
		begin
			tensVal = 4'd0;
			onesVal = pageCount[3:0];
		end
	end

	assign tensChar = ASCII_ZERO + {4'b0000, tensVal};
	assign onesChar = ASCII_ZERO + {4'b0000, onesVal};

	assign rowNumber = {ROW_NUMBER_PREFIX, tensChar, onesChar, ASCII_SPACE};
	assign rowTitle = ROW_TITLE;     // Fixed rows
	assign rowGreet1 = ROW_GREET1;
	assign rowGreet2 = ROW_GREET2;

	countRange: assert property (@(posedge CLOCK) disable iff (!RST_n)
		pageCount <= COUNT_MAX)
		else $error("pageCount out of range: %0d", pageCount);

endmodule

// ==== lcd_funcmod.sv ====
//******************************
// Display sequencer FSM
// Power-up wait, init commands,
// page repaint, A/B alternation
//******************************
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_funcmod
(
	input  logic              CLOCK,
	input  logic              RST_n,
	input  logic              run,         // Checked in idle only
	input  lcd_pkg::lcdRow_t  rowTitle,    // Page A upper row
	input  lcd_pkg::lcdRow_t  rowNumber,   // Page A lower row
	input  lcd_pkg::lcdRow_t  rowGreet1,   // Page B upper row
	input  lcd_pkg::lcdRow_t  rowGreet2,   // Page B lower row
	input  logic              busDone,
	output logic              busStart,    // One-cycle write request
	output logic              busRs,
	output lcd_pkg::lcdByte_t busData,
	output logic              pageDone,    // One cycle after last write of a page
	output logic              pageB        // Current page is B
);
	import lcd_pkg::*;

	localparam int POWERUP = `LCD_POWERUP_CYCLES;
	localparam int CLEAR = `LCD_CLEAR_CYCLES;
	localparam int WAIT_MAX = (POWERUP > CLEAR) ? POWERUP : CLEAR;
	localparam int WAIT_W = $clog2(WAIT_MAX + 1);

	// DDRAM address commands
	localparam lcdByte_t CMD_LINE1 = 8'h80;
	localparam lcdByte_t CMD_LINE2 = 8'hC0;

	funcState_t funcState;
	logic [WAIT_W-1:0] waitCnt;    // Power-up and clear delays
	logic [1:0] initIdx;           // Init command on the bus
	logic [4:0] charIdx;           // Character on the bus, 0..15
	logic rowLow;                  // Painting lower row
	lcdRow_t curRow;
	logic [3:0] nextIdx;
	lcdByte_t nextChar;

	// Init sequence
	function automatic lcdByte_t initCmdByte(input logic [1:0] idx);
		case (idx)
			2'd0: initCmdByte = 8'h38;    // 8-bit bus, 2 lines, 5x8 font
			2'd1: initCmdByte = 8'h0C;    // Display on, no cursor
			2'd2: initCmdByte = 8'h06;    // Increment, no shift
			default: initCmdByte = 8'h01; // Clear display
		endcase
	endfunction

	// Row for current page and line
	always_comb
	begin
		if (pageB)
			curRow = rowLow ? rowGreet2 : rowGreet1;
		else
			curRow = rowLow ? rowNumber : rowTitle;
	end

	// Char index for next write, first char right after address
	assign nextIdx = (funcState == rowAddr) ? 4'd0 : charIdx[3:0] + 4'd1;
	assign nextChar = curRow[{4'd15 - nextIdx, 3'b000} +: 8];   // Top byte first

	assign pageDone = (funcState == lcd_pkg::pageDone);

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			funcState <= powerUp;
			waitCnt <= '0;
			initIdx <= '0;
			charIdx <= '0;
			rowLow <= 1'b0;
			pageB <= 1'b0;       // First page is A
			busStart <= 1'b0;
			busRs <= 1'b0;
			busData <= '0;
		end
		else
		begin
			busStart <= 1'b0;    // Pulse by default
			case (funcState)
				powerUp:
					if (waitCnt == WAIT_W'(POWERUP - 1))
					begin
						funcState <= initCmd;
						initIdx <= '0;
						busStart <= 1'b1;
						busRs <= 1'b0;
						busData <= initCmdByte(2'd0);
					end
					else
						waitCnt <= waitCnt + 1'b1;
				initCmd:
					if (busDone)
					begin
						if (initIdx == 2'd3)
						begin
							funcState <= clearWait;   // Clear is slow on the panel
							waitCnt <= '0;
						end
						else
						begin
							initIdx <= initIdx + 2'd1;
							busStart <= 1'b1;
							busData <= initCmdByte(initIdx + 2'd1);
						end
					end
				clearWait:
					if (waitCnt == WAIT_W'(CLEAR - 1))
						funcState <= idle;
					else
						waitCnt <= waitCnt + 1'b1;
				idle:
					if (run)
					begin
						funcState <= rowAddr;
						rowLow <= 1'b0;
						busStart <= 1'b1;
						busRs <= 1'b0;
						busData <= CMD_LINE1;
					end
				rowAddr:
					if (busDone)
					begin
						funcState <= rowChars;
						charIdx <= '0;
						busStart <= 1'b1;
						busRs <= 1'b1;
						busData <= nextChar;
					end
				rowChars:
					if (busDone)
					begin
						if (charIdx == 5'd15)
						begin
							if (rowLow)
								funcState <= lcd_pkg::pageDone;
							else
							begin
								// Move to lower row
								funcState <= rowAddr;
								rowLow <= 1'b1;
								busStart <= 1'b1;
								busRs <= 1'b0;
								busData <= CMD_LINE2;
							end
						end
						else
						begin
							charIdx <= charIdx + 5'd1;
							busStart <= 1'b1;
							busData <= nextChar;
						end
					end
				lcd_pkg::pageDone:
				begin
					pageB <= ~pageB;   // Other page next time
					funcState <= idle;
				end
				default:
					funcState <= powerUp;
			endcase
		end
	end

	// Char index stays inside the row
	charIdxRange: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(funcState == rowChars) |-> (charIdx <= 5'd15))
		else $error("charIdx out of range: %0d", charIdx);

	// No bus traffic while the panel is settling
	noStartInWait: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(funcState == powerUp || funcState == clearWait) |-> !busStart)
		else $error("busStart during wait state %s", funcState.name());

endmodule

// ==== lcd_buswriter.sv ====
//******************************
// Display bus write cycle
// Setup, enable pulse, hold,
// then a done pulse
//******************************
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_buswriter
(
	input  logic              CLOCK,
	input  logic              RST_n,
	input  logic              start,    // Accepted in busIdle only
	input  logic              rs,
	input  lcd_pkg::lcdByte_t data,
	output logic              done,     // Last cycle of the write
	output logic              LCD_RS,
	output logic              LCD_EN,
	output lcd_pkg::lcdByte_t LCD_D
);
	import lcd_pkg::*;

	localparam int SETUP = `LCD_SETUP_CYCLES;
	localparam int PULSE = `LCD_PULSE_CYCLES;
	localparam int HOLD = `LCD_HOLD_CYCLES;
	localparam int PHASE_MAX = (SETUP > PULSE) ? ((SETUP > HOLD) ? SETUP : HOLD)
		: ((PULSE > HOLD) ? PULSE : HOLD);
	localparam int PHASE_W = $clog2(PHASE_MAX + 1);

	busState_t busState;
	logic [PHASE_W-1:0] phaseCnt;
	logic phaseEnd;       // Last cycle of current phase

	// Hold phase is one short, the idle cycle with next start completes it
	always_comb
	begin
		case (busState)
			busSetup: phaseEnd = (phaseCnt == PHASE_W'(SETUP - 1));
			busPulse: phaseEnd = (phaseCnt == PHASE_W'(PULSE - 1));
			busHold:  phaseEnd = (phaseCnt == PHASE_W'(HOLD - 2));
			default:  phaseEnd = 1'b0;
		endcase
	end

	assign done = (busState == busHold) && phaseEnd;

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			busState <= busIdle;
			phaseCnt <= '0;
			LCD_EN <= 1'b0;
			LCD_RS <= 1'b0;
			LCD_D <= '0;
		end
		else
		begin
			case (busState)
				busIdle:
					if (start)
					begin
						busState <= busSetup;
						phaseCnt <= '0;
						LCD_RS <= rs;      // Held until next start
						LCD_D <= data;
					end
				busSetup:
					if (phaseEnd)
					begin
						busState <= busPulse;
						phaseCnt <= '0;
						LCD_EN <= 1'b1;    // Rises SETUP edges after start
					end
					else
						phaseCnt <= phaseCnt + 1'b1;
				busPulse:
					if (phaseEnd)
					begin
						busState <= busHold;
						phaseCnt <= '0;
						LCD_EN <= 1'b0;    // Panel latches on this fall
					end
					else
						phaseCnt <= phaseCnt + 1'b1;
				busHold:
					if (phaseEnd)
						busState <= busIdle;
					else
						phaseCnt <= phaseCnt + 1'b1;
				default:
					busState <= busIdle;
			endcase
		end
	end

	// Sequencer waits for done before the next write
	startWhenIdle: assert property (@(posedge CLOCK) disable iff (!RST_n)
		start |-> (busState == busIdle))
		else $error("start during write, state %s", busState.name());

	enPulseWidth: assert property (@(posedge CLOCK) disable iff (!RST_n)
		$rose(LCD_EN) |-> LCD_EN [*`LCD_PULSE_CYCLES] ##1 !LCD_EN)
		else $error("LCD_EN pulse width not %0d cycles", PULSE);

	// Bus lines frozen while enable is high
	busStableOnEn: assert property (@(posedge CLOCK) disable iff (!RST_n)
		LCD_EN |-> ($stable(LCD_RS) && $stable(LCD_D)))
		else $error("LCD_RS or LCD_D changed with LCD_EN high");

endmodule

// ==== lcd_basemod.sv ====
//******************************
// Top level of the 1602 driver
// Text generator, sequencer and
// bus writer wired to the pins
//******************************
`timescale 1ns/10ps

module lcd_basemod
(
	input  logic              CLOCK,
	input  logic              RST_n,
	input  logic              run,      // Level, allows new pages
	output logic              LCD_RS,   // High for data, low for command
	output logic              LCD_RW,
	output logic              LCD_EN,
	output lcd_pkg::lcdByte_t LCD_D
);
	import lcd_pkg::*;

	// Row texts to the sequencer
	lcdRow_t rowTitle;
	lcdRow_t rowNumber;
	lcdRow_t rowGreet1;
	lcdRow_t rowGreet2;

	logic pageDone;     // End of page pulse
	logic pageB;        // Page type level
	logic busStart;
	logic busRs;
	logic busDone;
	lcdByte_t busData;

	assign LCD_RW = 1'b0;   // Never read, busy flag unused

	lcd_textgen textGen
	(
		.CLOCK     (CLOCK),
		.RST_n     (RST_n),
		.pageDone  (pageDone),
		.pageB     (pageB),
		.rowTitle  (rowTitle),
		.rowNumber (rowNumber),
		.rowGreet1 (rowGreet1),
		.rowGreet2 (rowGreet2)
	);

	lcd_funcmod funcMod
	(
		.CLOCK     (CLOCK),
		.RST_n     (RST_n),
		.run       (run),
		.rowTitle  (rowTitle),
		.rowNumber (rowNumber),
		.rowGreet1 (rowGreet1),
		.rowGreet2 (rowGreet2),
		.busDone   (busDone),
		.busStart  (busStart),
		.busRs     (busRs),
		.busData   (busData),
		.pageDone  (pageDone),
		.pageB     (pageB)
	);

	lcd_buswriter busWriter
	(
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.start  (busStart),
		.rs     (busRs),
		.data   (busData),
		.done   (busDone),
		.LCD_RS (LCD_RS),
		.LCD_EN (LCD_EN),
		.LCD_D  (LCD_D)
	);

endmodule

// ==== lcd_tb.sv ====
//******************************
// Testbench for the 1602 driver
// Clock, reset, bus decoder model,
// checks, watchdog and report
//******************************
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_tb;
	import lcd_pkg::*;

	localparam int SETUP = `LCD_SETUP_CYCLES;
	localparam int PULSE = `LCD_PULSE_CYCLES;
	localparam int BUS_CYCLES = `LCD_SETUP_CYCLES + `LCD_PULSE_CYCLES + `LCD_HOLD_CYCLES;
	localparam int PAGE_CYCLES = 34 * BUS_CYCLES + 2;   // Page plus pageDone and idle
	localparam int COUNT_WRAP = 17;                     // Counter runs 0..16
	localparam int QUIET_CYCLES = 2 * PAGE_CYCLES;      // Bus must stay silent this long
	localparam int TOTAL_PAGES = 2 * COUNT_WRAP + 4;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_PAGES * PAGE_CYCLES + QUIET_CYCLES
		+ `LCD_POWERUP_CYCLES + 4 * BUS_CYCLES + `LCD_CLEAR_CYCLES);

	localparam lcdByte_t INIT_SEQ [4] = '{8'h38, 8'h0C, 8'h06, 8'h01};

	logic CLOCK;
	logic RST_n;
	logic run;
	logic LCD_RS;
	logic LCD_RW;
	logic LCD_EN;
	lcdByte_t LCD_D;

	int seed = 2;
	int errCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	// Bus decoder model state
	logic resetReleased = 1'b0;   // Reset level taken at the rising edge
	int cycle = 0;
	logic enPrev = 1'b0;
	logic rsPrev = 1'b0;
	lcdByte_t dPrev = '0;
	int lastBusChange = 0;    // Last cycle RS or D moved
	int riseCycle = 0;
	int riseCount = 0;
	int riseAt[$];
	int fallAt[$];
	logic wrRs[$];
	lcdByte_t wrData[$];
	logic inPage = 1'b0;
	int rowSel = 0;
	int colIdx = 0;
	int pageWrites = 0;
	lcdRow_t rowBuf [2];
	int pagesDone = 0;
	int pageACount = 0;       // Model's own page pair count
	logic lastSeenB = 1'b0;   // Type of last finished page by its text
	logic [15:0] lastDigits;

	initial CLOCK = 1'b0;
	always #5 CLOCK = ~CLOCK;

	lcd_basemod lcd_basemod_i
	(
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.run    (run),
		.LCD_RS (LCD_RS),
		.LCD_RW (LCD_RW),
		.LCD_EN (LCD_EN),
		.LCD_D  (LCD_D)
	);

	task automatic reportMismatch(input string sig, input logic [127:0] expVal,
		input logic [127:0] actVal);
		errCount++;
		$display("error at %0t: %s expected %0h got %0h", $time, sig, expVal, actVal);
	endtask

	task automatic reportProblem(input string msg);
		errCount++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic closeTest(input int num, input string name, input int errBefore);
		if (errCount == errBefore)
		begin
			testsPassed++;
			$display("test %0d %s: passed", num, name);
		end
		else
		begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", num, name, errCount - errBefore);
		end
	endtask

	// Counter row from prefix and decimal digits
	function automatic lcdRow_t numberRow(input int n);
		lcdByte_t tens;
		lcdByte_t ones;
		tens = 8'h30 + lcdByte_t'(n / 10);
		ones = 8'h30 + lcdByte_t'(n % 10);
		numberRow = {ROW_NUMBER_PREFIX, tens, ones, 8'h20};
	endfunction

	task automatic finishPage();
		// Even pages are A and odd pages B
		lastSeenB = (rowBuf[0] == ROW_GREET1);
		assert (pageWrites == 34) else reportMismatch("page write count", 34, pageWrites);
		if (pagesDone % 2 == 0)
		begin
			assert (rowBuf[0] == ROW_TITLE)
				else reportMismatch("LCD_D page A upper row", ROW_TITLE, rowBuf[0]);
			assert (rowBuf[1] == numberRow(pageACount % COUNT_WRAP))
				else reportMismatch("LCD_D page A lower row",
					numberRow(pageACount % COUNT_WRAP), rowBuf[1]);
			lastDigits = rowBuf[1][23:8];
			pageACount++;
		end
		else
		begin
			assert (rowBuf[0] == ROW_GREET1)
				else reportMismatch("LCD_D page B upper row", ROW_GREET1, rowBuf[0]);
			assert (rowBuf[1] == ROW_GREET2)
				else reportMismatch("LCD_D page B lower row", ROW_GREET2, rowBuf[1]);
		end
		pagesDone++;
		inPage = 1'b0;
	endtask

	// One decoded write moving the cursor row and column
	task automatic captureWrite(input logic rs, input lcdByte_t d);
		wrRs.push_back(rs);
		wrData.push_back(d);
		if (!rs && d == 8'h80)
		begin
			inPage = 1'b1;
			rowSel = 0;
			colIdx = 0;
			pageWrites = 1;
		end
		else if (inPage)
		begin
			pageWrites++;
			if (!rs && d == 8'hC0)
			begin
				assert (rowSel == 0 && colIdx == 16)
					else reportProblem("lower row address before the upper row was full");
				rowSel = 1;
				colIdx = 0;
			end
			else if (rs && colIdx < 16)
			begin
				rowBuf[rowSel][(15 - colIdx) * 8 +: 8] = d;   // Leftmost char in top byte
				colIdx++;
				if (rowSel == 1 && colIdx == 16)
					finishPage();
			end
			else
				reportProblem("unexpected write inside a page");
		end
		else if (rs)
			reportProblem("character write outside a page");
	endtask

	always @(posedge CLOCK)
		resetReleased <= RST_n;

	// Decoder samples on the falling clock where outputs have settled
	always @(negedge CLOCK)
	begin
		if (resetReleased)
		begin
			cycle++;
			if (LCD_RS !== rsPrev || LCD_D !== dPrev)
				lastBusChange = cycle;
			if (LCD_EN && !enPrev)
			begin
				riseCycle = cycle;
				riseAt.push_back(cycle);
				riseCount++;
			end
			if (!LCD_EN && enPrev)
			begin
				fallAt.push_back(cycle);
				assert (cycle - riseCycle == PULSE)
					else reportMismatch("LCD_EN high cycles", PULSE, cycle - riseCycle);
				// RS and D quiet from SETUP before the rise up to here
				assert (riseCycle - lastBusChange >= SETUP)
					else reportProblem("LCD_RS or LCD_D not stable around the enable pulse");
				captureWrite(LCD_RS, LCD_D);
			end
			rsPrev = LCD_RS;
			dPrev = LCD_D;
			enPrev = LCD_EN;
		end
	end

	rwNeverHigh: assert property (@(posedge CLOCK) disable iff (!RST_n) !LCD_RW)
		else reportMismatch("LCD_RW", 0, LCD_RW);

	busFrozenOnEn: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(LCD_EN && $past(LCD_EN)) |-> ($stable(LCD_RS) && $stable(LCD_D)))
		else reportProblem("LCD_RS or LCD_D changed while LCD_EN was high");

	initial
	begin
		int errBefore;
		int target;
		int stopPages;
		int stopRises;
		logic stopB;
		RST_n = 1'b0;
		run = 1'b1;
		repeat (3) @(negedge CLOCK);

		errBefore = errCount;
		assert (LCD_EN === 1'b0) else reportMismatch("LCD_EN", 0, LCD_EN);
		assert (LCD_RS === 1'b0) else reportMismatch("LCD_RS", 0, LCD_RS);
		assert (LCD_RW === 1'b0) else reportMismatch("LCD_RW", 0, LCD_RW);
		assert (LCD_D === 8'h00) else reportMismatch("LCD_D", 0, LCD_D);
		RST_n = 1'b1;
		wait (riseCount >= 1);
		assert (riseAt[0] > `LCD_POWERUP_CYCLES)
			else reportProblem("LCD_EN pulse inside the power-up wait");
		closeTest(1, "reset and power-up wait", errBefore);

		errBefore = errCount;
		wait (riseCount >= 5);
		for (int i = 0; i < 4; i++)
		begin
			assert (wrRs[i] == 1'b0) else reportMismatch("LCD_RS init write", 0, wrRs[i]);
			assert (wrData[i] == INIT_SEQ[i])
				else reportMismatch("LCD_D init write", INIT_SEQ[i], wrData[i]);
		end
		assert (riseAt[4] - fallAt[3] >= `LCD_CLEAR_CYCLES + SETUP)
			else reportProblem("next write came too soon after the clear command");
		closeTest(2, "init commands and clear wait", errBefore);

		errBefore = errCount;
		wait (pagesDone >= 1);
		closeTest(3, "enable pulse and bus stability", errBefore);

		errBefore = errCount;
		wait (pagesDone >= 4);
		closeTest(4, "page alternation", errBefore);

		errBefore = errCount;
		wait (pageACount >= COUNT_WRAP + 1);
		assert (lastDigits == 16'h3030)   // "00" after the wrap
			else reportMismatch("LCD_D counter digits", 16'h3030, lastDigits);
		closeTest(5, "counter row and wrap", errBefore);

		errBefore = errCount;
		target = 2 + ($unsigned($random(seed)) % 30);
		stopPages = pagesDone;
		wait (inPage && pageWrites >= target);
		@(negedge CLOCK);
		run = 1'b0;   // Mid page
		wait (pagesDone > stopPages);
		stopB = lastSeenB;
		stopRises = riseCount;
		repeat (QUIET_CYCLES) @(negedge CLOCK);
		assert (riseCount == stopRises) else reportProblem("LCD_EN pulse after run dropped");
		run = 1'b1;
		wait (pagesDone > stopPages + 1);
		assert (lastSeenB != stopB) else reportProblem("same page type repeated after run rose");
		closeTest(6, "run drop and restart", errBefore);

		$display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errCount);
		if (testsFailed == 0 && errCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Hang guard sized from page count and start-up time
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
lcd_pkg.sv
lcd_textgen.sv
lcd_funcmod.sv
lcd_buswriter.sv
lcd_basemod.sv
lcd_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the 1602 driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module lcd_tb -o lcd_sim

simOut=$(./obj_dir/lcd_sim)
echo "$simOut"

if echo "$simOut" | grep -qx "TEST OK"; then
	exit 0
else
	exit 1
fi
